// ==== ifu_cfg_pkg.sv ====
`default_nettype none

package ifu_cfg_pkg;

   // ************************************************************
   // Address and fetch word geometry
   // ************************************************************
   localparam int addr_w   = 32;                   // Byte address width
   localparam int fetch_w  = 64;                   // One bus beat per fetch word
   localparam int parcel_w = 16;                   // RVC parcel size
   localparam int parcels  = fetch_w / parcel_w;   // Parcels in one fetch word
   localparam int ptr_w    = 2;                    // Parcel index, byte address bits 2:1

   // ************************************************************
   // Queue sizing
   // ************************************************************
   localparam int pend_depth = 4;   // Outstanding bus requests
   localparam int fbuf_depth = 4;   // Fetch words waiting for the aligner

   // Boot vector, word aligned
   localparam logic [addr_w-1:0] reset_pc = 32'h0000_1000;

endpackage

`default_nettype wire

// ==== ifu_pkt_pkg.sv ====
`default_nettype none

package ifu_pkt_pkg;

   import ifu_cfg_pkg::*;

   // ************************************************************
   // Instruction memory bus payloads
   // ************************************************************
   typedef struct packed {
      logic [addr_w-1:0]  addr;   // Word aligned fetch address
   } fetch_req_t;

   typedef struct packed {
      logic [fetch_w-1:0] data;   // Whole fetch word
      logic               err;    // Bus error on this beat
   } fetch_rsp_t;

   // ************************************************************
   // Internal queue entries
   // ************************************************************
   typedef struct packed {
      logic [addr_w-1:ptr_w+1] waddr;   // Word address of the issued request
      logic                    epoch;   // Stream tag at issue time
   } pend_t;

   typedef struct packed {
      logic [fetch_w-1:0]      data;    // Fetch word as returned
      logic [addr_w-1:ptr_w+1] waddr;   // Word address from the pending queue
      logic                    err;     // Whole word faulted
   } fetch_pkt_t;

   // Aligned instruction toward decode
   typedef struct packed {
      logic [31:0]        instr;         // Upper half zero for 2 byte ops
      logic [addr_w-1:0]  pc;            // Byte address of first parcel
      logic               pc4;           // 4 byte instruction
      logic               icaf;          // Access fault
      logic               icaf_second;   // Fault only on the upper half
   } inst_t;

endpackage

`default_nettype wire

// ==== ifu_fifo.sv ====
`default_nettype none

module ifu_fifo #(
   parameter type T     = logic,
   parameter int  depth = 4
) (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         clear,        // Drop all entries
   input  logic                         push_valid,
   output logic                         push_ready,
   input  T                             push_data,
   output logic                         pop_valid,
   input  logic                         pop_ready,
   output T                             pop_data,
   output logic [$clog2(depth+1)-1:0]   count         // Entries held
);

   T                           mem [depth];   // Payload storage
   logic [$clog2(depth)-1:0]   wr_ptr;        // Next slot to fill
   logic [$clog2(depth)-1:0]   rd_ptr;        // Head slot
   logic                       do_push;
   logic                       do_pop;

   assign push_ready = (int'(count) != depth);   // Room left
   assign pop_valid  = (count != '0);            // Head is live
   assign pop_data   = mem[rd_ptr];              // Head shown without a pop
   assign do_push    = push_valid & push_ready;
   assign do_pop     = pop_valid & pop_ready;

   // ************************************************************
   // Pointers and occupancy
   // ************************************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (clear) begin   // Clear wins over any push or pop
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (int'(wr_ptr) == depth - 1) ? '0 : wr_ptr + 1'b1;   // Wrap at depth
         end
         if (do_pop) begin
            rd_ptr <= (int'(rd_ptr) == depth - 1) ? '0 : rd_ptr + 1'b1;
         end
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;   // Stale slots are overwritten later
      end
   end

endmodule

`default_nettype wire

// ==== ifu_fetch_ctl.sv ====
`default_nettype none

module ifu_fetch_ctl (
   input  logic                                       clk,
   input  logic                                       rst_n,
   input  logic                                       flush,        // Redirect pulse
   input  logic [ifu_cfg_pkg::addr_w-1:0]             flush_path,   // Redirect target
   output logic                                       req_valid,
   input  logic                                       req_ready,
   output ifu_pkt_pkg::fetch_req_t                    req,
   input  logic                                       rsp_valid,
   output logic                                       rsp_ready,
   input  ifu_pkt_pkg::fetch_rsp_t                    rsp,
   output logic                                       push_valid,   // To fetch buffer
   output ifu_pkt_pkg::fetch_pkt_t                    push_pkt,
   input  logic [$clog2(ifu_cfg_pkg::fbuf_depth+1)-1:0] buf_count   // Fetch buffer fill
);

   import ifu_cfg_pkg::*;
   import ifu_pkt_pkg::*;

   logic [addr_w-1:ptr_w+1]          fetch_waddr;       // Next word to request
   logic                             epoch;             // Current stream tag
   logic                             run;               // Low until reset is gone
   logic                             credit_ok;
   logic                             req_hs;
   logic                             rsp_hs;
   pend_t                            pend_in;
   pend_t                            pend_head;
   logic                             pend_push_ready;
   logic                             pend_valid;
   logic [$clog2(pend_depth+1)-1:0]  pend_cnt;

   // ************************************************************
   // Request side
   // ************************************************************

   // Every outstanding word must find a buffer slot on return
   assign credit_ok = (int'(pend_cnt) + int'(buf_count)) < fbuf_depth;
   assign req_valid = run & credit_ok & pend_push_ready;
   assign req.addr  = {fetch_waddr, {(ptr_w+1){1'b0}}};   // Word aligned
   assign req_hs    = req_valid & req_ready;

   assign pend_in.waddr = fetch_waddr;   // Remember where the beat belongs
   assign pend_in.epoch = epoch;         // Old tag if issued in the flush cycle

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         fetch_waddr <= reset_pc[addr_w-1:ptr_w+1];
         epoch       <= 1'b0;
         run         <= 1'b0;
      end else begin
         run <= 1'b1;
         if (flush) begin
            fetch_waddr <= flush_path[addr_w-1:ptr_w+1];   // Round down to a word
            epoch       <= ~epoch;                         // Orphan everything in flight
         end else if (req_hs) begin
            fetch_waddr <= fetch_waddr + 1'b1;             // Next 8 bytes
         end
      end
   end

   // Addresses of issued requests in bus order, never flushed
   ifu_fifo #(
      .T     (pend_t),
      .depth (pend_depth)
   ) pend_q (
      .clk        (clk),
      .rst_n      (rst_n),
      .clear      (1'b0),             // Stale beats still arrive
      .push_valid (req_hs),
      .push_ready (pend_push_ready),
      .push_data  (pend_in),
      .pop_valid  (pend_valid),
      .pop_ready  (rsp_valid),        // One entry per response beat
      .pop_data   (pend_head),
      .count      (pend_cnt)
   );

   // ************************************************************
   // Response side
   // ************************************************************
   assign rsp_ready = pend_valid;               // Accept whenever a request is open
   assign rsp_hs    = rsp_valid & rsp_ready;

   // Beats from an older stream are taken off the bus and dropped
   assign push_valid     = rsp_hs & (pend_head.epoch == epoch);
   assign push_pkt.data  = rsp.data;
   assign push_pkt.waddr = pend_head.waddr;
   assign push_pkt.err   = rsp.err;

endmodule

`default_nettype wire

// ==== ifu_aligner.sv ====
`default_nettype none

module ifu_aligner (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            flush,
   input  logic [ifu_cfg_pkg::addr_w-1:0]  flush_path,
   input  logic                            pop_valid,    // Fetch buffer head live
   output logic                            pop_ready,
   input  ifu_pkt_pkg::fetch_pkt_t         pop_pkt,
   output logic                            inst_valid,
   input  logic                            dec_ready,
   output ifu_pkt_pkg::inst_t              inst
);

   import ifu_cfg_pkg::*;
   import ifu_pkt_pkg::*;

   logic [ptr_w-1:0]     ptr;           // Parcel to use next in the head word
   logic [ptr_w-1:0]     ptr_next;
   logic [ptr_w-1:0]     ptr_inc1;
   logic                 have_left;     // Low half of a split op is held
   logic [parcel_w-1:0]  left_parcel;
   logic [addr_w-1:0]    left_pc;
   logic [parcel_w-1:0]  parcel;        // Parcel at ptr
   logic [parcel_w-1:0]  next_parcel;   // Parcel after it
   logic [addr_w-1:0]    cur_pc;
   logic                 is_long;
   logic                 emit;          // This step yields an instruction
   logic                 save;          // This step parks a low half
   logic                 last;          // Head word is used up
   logic                 slot_free;
   logic                 step;
   inst_t                nxt_inst;

   assign ptr_inc1    = ptr + 1'b1;
   assign parcel      = pop_pkt.data[ptr*parcel_w +: parcel_w];
   assign next_parcel = pop_pkt.data[ptr_inc1*parcel_w +: parcel_w];
   assign cur_pc      = {pop_pkt.waddr, ptr, 1'b0};
   assign is_long     = &parcel[1:0];   // 11 in the low bits means 32 bit op

   // ************************************************************
   // Length decode and fault marking
   // ************************************************************
   always_comb begin
      nxt_inst = '0;
      emit     = 1'b0;
      save     = 1'b0;
      last     = 1'b0;
      ptr_next = ptr;
      if (have_left) begin                        // Upper half is parcel 0 of this word
         emit         = 1'b1;
         nxt_inst.pc  = left_pc;
         nxt_inst.pc4 = 1'b1;
         ptr_next     = ptr_w'(1);
         if (pop_pkt.err) begin
            nxt_inst.instr       = {16'h0, left_parcel};   // Good low half kept
            nxt_inst.icaf        = 1'b1;
            nxt_inst.icaf_second = 1'b1;
         end else begin
            nxt_inst.instr = {pop_pkt.data[parcel_w-1:0], left_parcel};
         end
      end else if (pop_pkt.err) begin
         emit          = 1'b1;                    // Faulted parcel as a 2 byte op
         nxt_inst.pc   = cur_pc;
         nxt_inst.icaf = 1'b1;
         ptr_next      = ptr_inc1;
         last          = (int'(ptr) == parcels - 1);
      end else if (is_long) begin
         if (int'(ptr) == parcels - 1) begin      // Crosses into the next word
            save     = 1'b1;
            last     = 1'b1;
            ptr_next = '0;
         end else begin
            emit           = 1'b1;
            nxt_inst.instr = {next_parcel, parcel};
            nxt_inst.pc    = cur_pc;
            nxt_inst.pc4   = 1'b1;
            ptr_next       = ptr + ptr_w'(2);
            last           = (int'(ptr) == parcels - 2);
         end
      end else begin
         emit           = 1'b1;                   // Compressed
         nxt_inst.instr = {16'h0, parcel};
         nxt_inst.pc    = cur_pc;
         ptr_next       = ptr_inc1;
         last           = (int'(ptr) == parcels - 1);
      end
   end

   // Parking a low half needs no output slot
   assign slot_free = ~inst_valid | dec_ready;
   assign step      = pop_valid & (slot_free | ~emit);
   assign pop_ready = step & last;

   // ************************************************************
   // State update
   // ************************************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ptr        <= reset_pc[ptr_w:1];
         have_left  <= 1'b0;
         inst_valid <= 1'b0;
      end else if (flush) begin
         ptr        <= flush_path[ptr_w:1];   // May start mid word
         have_left  <= 1'b0;
         inst_valid <= 1'b0;
      end else begin
         if (step) begin
            ptr       <= ptr_next;
            have_left <= save;                // Held half is consumed or replaced
         end
         if (step && emit) begin
            inst_valid <= 1'b1;
         end else if (dec_ready) begin
            inst_valid <= 1'b0;               // Decode took it
         end
      end
   end

   always_ff @(posedge clk) begin
      if (step && save) begin
         left_parcel <= parcel;
         left_pc     <= cur_pc;
      end
      if (step && emit) begin
         inst <= nxt_inst;                    // Holds while decode stalls
      end
   end

endmodule

`default_nettype wire

// ==== ifu_top.sv ====
`default_nettype none

module ifu_top (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            flush,
   input  logic [ifu_cfg_pkg::addr_w-1:0]  flush_path,
   output logic                            req_valid,
   input  logic                            req_ready,
   output ifu_pkt_pkg::fetch_req_t         req,
   input  logic                            rsp_valid,
   output logic                            rsp_ready,
   input  ifu_pkt_pkg::fetch_rsp_t         rsp,
   output logic                            inst_valid,
   input  logic                            dec_ready,
   output ifu_pkt_pkg::inst_t              inst
);

   import ifu_cfg_pkg::*;
   import ifu_pkt_pkg::*;

   logic                              fb_push_valid;
   fetch_pkt_t                        fb_push_pkt;
   logic                              fb_pop_valid;
   logic                              fb_pop_ready;
   fetch_pkt_t                        fb_pop_pkt;
   logic [$clog2(fbuf_depth+1)-1:0]   fb_count;

   // ************************************************************
   // Fetch control, fetch buffer, aligner
   // ************************************************************
   ifu_fetch_ctl ifc (
      .clk        (clk),
      .rst_n      (rst_n),
      .flush      (flush),
      .flush_path (flush_path),
      .req_valid  (req_valid),
      .req_ready  (req_ready),
      .req        (req),
      .rsp_valid  (rsp_valid),
      .rsp_ready  (rsp_ready),
      .rsp        (rsp),
      .push_valid (fb_push_valid),
      .push_pkt   (fb_push_pkt),
      .buf_count  (fb_count)        // Feeds the credit check
   );

   // Credit check keeps a slot free for every beat, so push_ready stays open
   ifu_fifo #(
      .T     (fetch_pkt_t),
      .depth (fbuf_depth)
   ) fbuf (
      .clk        (clk),
      .rst_n      (rst_n),
      .clear      (flush),          // Old stream words go away
      .push_valid (fb_push_valid),
      .push_ready (),
      .push_data  (fb_push_pkt),
      .pop_valid  (fb_pop_valid),
      .pop_ready  (fb_pop_ready),
      .pop_data   (fb_pop_pkt),
      .count      (fb_count)
   );

   ifu_aligner aln (
      .clk        (clk),
      .rst_n      (rst_n),
      .flush      (flush),
      .flush_path (flush_path),     // Start parcel after a redirect
      .pop_valid  (fb_pop_valid),
      .pop_ready  (fb_pop_ready),
      .pop_pkt    (fb_pop_pkt),
      .inst_valid (inst_valid),
      .dec_ready  (dec_ready),
      .inst       (inst)
   );

endmodule

`default_nettype wire

// ==== ifu_props.sv ====
`default_nettype none

module ifu_props (
   input logic                            clk,
   input logic                            rst_n,
   input logic                            flush,
   input logic                            req_valid,
   input logic                            req_ready,
   input ifu_pkt_pkg::fetch_req_t         req,
   input logic                            rsp_valid,
   input logic                            rsp_ready,
   input logic                            inst_valid,
   input logic                            dec_ready,
   input ifu_pkt_pkg::inst_t              inst
);

   int unsigned open_reqs;   // Requests taken by the bus and not yet answered

   always @(posedge clk) begin
      if (!rst_n) begin
         open_reqs <= 0;
      end else begin
         open_reqs <= open_reqs + 32'(req_valid & req_ready) - 32'(rsp_valid & rsp_ready);
      end
   end

   // ************************************************************
   // Handshake rules
   // ************************************************************
   req_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
      req_valid && !req_ready && !flush |=> req_valid && $stable(req))
      else $error("req changed or dropped while waiting for req_ready");

   inst_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
      inst_valid && !dec_ready && !flush |=> inst_valid && $stable(inst))
      else $error("inst changed or dropped while decode stalled");

   rsp_open_a: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid |-> open_reqs != 0)
      else $error("rsp_valid with no request outstanding");

   reset_quiet_a: assert property (@(posedge clk)
      !rst_n |=> !req_valid && !inst_valid && !rsp_ready)
      else $error("req_valid, inst_valid or rsp_ready high out of reset");

endmodule

`default_nettype wire

// ==== ifu_checker.sv ====
`default_nettype none

module ifu_checker #(
   parameter logic [ifu_cfg_pkg::addr_w-1:0] fault_lo = '0,   // First faulting byte
   parameter logic [ifu_cfg_pkg::addr_w-1:0] fault_hi = '0    // Last faulting byte
) (
   input logic                                     clk,
   input logic                                     rst_n,
   input logic                                     flush,
   input logic [ifu_cfg_pkg::addr_w-1:0]           flush_path,
   input logic                                     req_valid,
   input logic                                     req_ready,
   input ifu_pkt_pkg::fetch_req_t                  req,
   input logic                                     inst_valid,
   input logic                                     dec_ready,
   input ifu_pkt_pkg::inst_t                       inst,
   input logic [15:0][ifu_cfg_pkg::fetch_w-1:0]    image        // Memory image, mod 16
);

   import ifu_cfg_pkg::*;
   import ifu_pkt_pkg::*;

   int                 checked   = 0;          // Decode handshakes seen
   int                 errors    = 0;
   logic [addr_w-1:0]  exp_pc    = reset_pc;   // Where the stream should be
   logic               was_reset = 1'b0;
   logic               req_seen  = 1'b0;       // First request after reset done

   function automatic logic faulted(input logic [addr_w-1:0] addr);
      logic [addr_w-1:0] waddr;
      waddr = {addr[addr_w-1:3], 3'b000};
      return (waddr >= fault_lo) && (waddr <= fault_hi);
   endfunction

   function automatic logic [parcel_w-1:0] parcel_at(input logic [addr_w-1:0] addr);
      logic [fetch_w-1:0] word;
      word = image[addr[6:3]];
      return word[addr[2:1]*parcel_w +: parcel_w];
   endfunction

   // ************************************************************
   // Reference walk of the image
   // ************************************************************
   function automatic inst_t expect_at(input logic [addr_w-1:0] pc);
      inst_t              e;
      logic [parcel_w-1:0] lo;
      logic [addr_w-1:0]   upper_pc;
      e        = '0;
      e.pc     = pc;
      lo       = parcel_at(pc);
      upper_pc = pc + 32'd2;
      if (faulted(pc)) begin
         e.icaf = 1'b1;                               // Bad word gives a zero 2 byte op
      end else if (lo[1:0] != 2'b11) begin
         e.instr = {16'h0, lo};                       // Compressed
      end else begin
         e.pc4 = 1'b1;
         if (faulted(upper_pc)) begin                 // Upper half in a bad word
            e.instr       = {16'h0, lo};
            e.icaf        = 1'b1;
            e.icaf_second = 1'b1;
         end else begin
            e.instr = {parcel_at(upper_pc), lo};      // May come from the next word
         end
      end
      return e;
   endfunction

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("Mismatch %s: got %h expected %h (pc %h)", name, got, exp, exp_pc);
         errors++;
      end
   endtask

   always @(posedge clk) begin
      inst_t e;
      if (!rst_n) begin
         exp_pc   = reset_pc;
         req_seen = 1'b0;
      end else begin
         if (req_valid && req_ready && !req_seen) begin
            compare("req.addr", req.addr, reset_pc);   // Boot fetch
            req_seen = 1'b1;
         end
         if (inst_valid && dec_ready) begin
            e = expect_at(exp_pc);
            compare("inst.pc", inst.pc, e.pc);
            compare("inst.instr", inst.instr, e.instr);
            compare("inst.pc4", 32'(inst.pc4), 32'(e.pc4));
            compare("inst.icaf", 32'(inst.icaf), 32'(e.icaf));
            compare("inst.icaf_second", 32'(inst.icaf_second), 32'(e.icaf_second));
            checked++;
            exp_pc = exp_pc + (e.pc4 ? 32'd4 : 32'd2);
         end
         if (flush) begin
            exp_pc = flush_path;                       // New stream starts here
         end
      end
      if (was_reset) begin                             // Outputs must be quiet
         if (req_valid !== 1'b0) begin
            $display("Error: req_valid is not low during or right after reset");
            errors++;
         end
         if (inst_valid !== 1'b0) begin
            $display("Error: inst_valid is not low during or right after reset");
            errors++;
         end
      end
      was_reset = !rst_n;
   end

endmodule

`default_nettype wire

// ==== tb_ifu.sv ====
`default_nettype none

module tb_ifu;

   import ifu_cfg_pkg::*;
   import ifu_pkt_pkg::*;

   localparam logic [addr_w-1:0] fault_lo    = 32'h0000_2040;   // Two faulting words
   localparam logic [addr_w-1:0] fault_hi    = 32'h0000_204f;
   localparam int                n_rows      = 5;
   localparam int                row_timeout = 2000;            // Cycles per row

   typedef struct packed {
      logic [addr_w-1:0] target;   // Flush address, row 0 runs from reset
      logic [15:0]       count;    // Instructions to see
      logic              toggle;   // Random dec_ready
   } row_t;

   logic                      clk       = 1'b0;
   logic                      rst_n     = 1'b0;
   logic                      flush;
   logic [addr_w-1:0]         flush_path;
   logic                      req_valid;
   logic                      req_ready;
   fetch_req_t                req;
   logic                      rsp_valid;
   logic                      rsp_ready;
   fetch_rsp_t                rsp;
   logic                      inst_valid;
   logic                      dec_ready;
   inst_t                     inst;

   logic [15:0][fetch_w-1:0]  image;
   row_t                      rows [n_rows];
   logic [addr_w-1:0]         addr_q [$];         // Accepted request addresses
   logic                      rsp_taken = 1'b0;
   logic                      in_reset  = 1'b1;   // Sampled at posedge
   logic                      toggle_en = 1'b0;
   logic                      rand_dec  = 1'b0;
   int                        idle      = 0;      // Wait before next beat
   bit                        timed_out = 1'b0;

   initial begin
      forever #4 clk = ~clk;
   end

   ifu_top DUT (
      .clk        (clk),
      .rst_n      (rst_n),
      .flush      (flush),
      .flush_path (flush_path),
      .req_valid  (req_valid),
      .req_ready  (req_ready),
      .req        (req),
      .rsp_valid  (rsp_valid),
      .rsp_ready  (rsp_ready),
      .rsp        (rsp),
      .inst_valid (inst_valid),
      .dec_ready  (dec_ready),
      .inst       (inst)
   );

   ifu_checker #(
      .fault_lo (fault_lo),
      .fault_hi (fault_hi)
   ) chk (
      .clk        (clk),
      .rst_n      (rst_n),
      .flush      (flush),
      .flush_path (flush_path),
      .req_valid  (req_valid),
      .req_ready  (req_ready),
      .req        (req),
      .inst_valid (inst_valid),
      .dec_ready  (dec_ready),
      .inst       (inst),
      .image      (image)
   );

   bind ifu_top ifu_props props (
      .clk        (clk),
      .rst_n      (rst_n),
      .flush      (flush),
      .req_valid  (req_valid),
      .req_ready  (req_ready),
      .req        (req),
      .rsp_valid  (rsp_valid),
      .rsp_ready  (rsp_ready),
      .inst_valid (inst_valid),
      .dec_ready  (dec_ready),
      .inst       (inst)
   );

   // ************************************************************
   // Memory image and redirect table
   // ************************************************************
   task automatic load_image();
      image[0]  = 64'h4209_1111_0513_4101;
      image[1]  = 64'h0693_4519_4415_4311;   // Parcel 3 spans into word 2
      image[2]  = 64'h4621_3333_0713_2222;
      image[3]  = 64'h0a93_4444_0893_4725;
      image[4]  = 64'h0b13_492d_4829_5555;
      image[5]  = 64'h7777_0c13_4a31_6666;
      image[6]  = 64'h4e41_4d3d_4c39_4b35;   // All compressed
      image[7]  = 64'h0e93_8888_0d13_4f45;   // Spans into the fault window at 0x2038
      image[8]  = 64'h5251_514d_5049_9999;
      image[9]  = 64'h0f13_5355_1010_0f93;
      image[10] = 64'h5861_575d_5659_abcd;
      image[11] = 64'h5a69_1093_5965_1193;
      image[12] = 64'h5c71_5b6d_1212_1313;
      image[13] = 64'h1393_5e79_5d75_1414;
      image[14] = 64'h6081_5f7d_1513_2424;
      image[15] = 64'h1693_6285_6189_1616;   // Wraps into word 0
   endtask

   task automatic load_rows();
      rows[0] = '{reset_pc,       16'd30, 1'b0};   // Straight run from reset
      rows[1] = '{32'h0000_1016,  16'd20, 1'b0};   // Odd parcel target
      rows[2] = '{32'h0000_1000,  16'd40, 1'b1};   // Same stream under stalls
      rows[3] = '{32'h0000_2032,  16'd16, 1'b0};   // Runs through the fault window
      rows[4] = '{32'h0000_103a,  16'd24, 1'b1};
   endtask

   function automatic fetch_rsp_t mem_read(input logic [addr_w-1:0] addr);
      fetch_rsp_t r;
      if (addr >= fault_lo && addr <= fault_hi) begin
         r.data = '0;
         r.err  = 1'b1;
      end else begin
         r.data = image[addr[6:3]];
         r.err  = 1'b0;
      end
      return r;
   endfunction

   // ************************************************************
   // Bus and decode model
   // ************************************************************
   always @(posedge clk) begin
      in_reset  = !rst_n;
      rand_dec  = toggle_en;
      rsp_taken = rsp_valid & rsp_ready;
      if (rst_n && req_valid && req_ready) begin
         addr_q.push_back(req.addr);   // Answered in this order
      end
   end

   always @(negedge clk) begin
      if (in_reset) begin
         req_ready = 1'b0;
         rsp_valid = 1'b0;
         rsp       = '0;
         idle      = 0;
         dec_ready = 1'b1;
         addr_q.delete();
      end else begin
         req_ready = ($urandom_range(3, 0) != 0);                      // Busy one cycle in four
         dec_ready = rand_dec ? ($urandom_range(1, 0) == 1) : 1'b1;
         if (rsp_taken) begin
            rsp_valid = 1'b0;
            void'(addr_q.pop_front());
            idle = $urandom_range(3, 0);
         end
         if (!rsp_valid && addr_q.size() != 0) begin
            if (idle == 0) begin
               rsp_valid = 1'b1;
               rsp       = mem_read(addr_q[0]);
            end else begin
               idle--;
            end
         end
      end
   end

   task automatic wait_insts(input int row, input int n);
      int start;
      int cycles;
      start  = chk.checked;
      cycles = 0;
      while (chk.checked - start < n && !timed_out) begin
         @(negedge clk);
         cycles++;
         if (cycles > row_timeout) begin
            $display("Timeout: row %0d saw %0d of %0d instructions",
                     row, chk.checked - start, n);
            timed_out = 1'b1;
         end
      end
   endtask

   // ************************************************************
   // Main sequence
   // ************************************************************
   initial begin
      int err_start;
      int got_start;
      int rows_done;
      void'($urandom(32'h217a1360));
      load_image();
      load_rows();
      flush      = 1'b0;
      flush_path = '0;
      req_ready  = 1'b0;
      rsp_valid  = 1'b0;
      rsp        = '0;
      dec_ready  = 1'b1;
      rows_done  = 0;
      repeat (3) @(negedge clk);
      rst_n = 1'b1;
      for (int r = 0; r < n_rows && !timed_out; r++) begin
         if (r > 0) begin
            @(negedge clk);
            flush      = 1'b1;                // One cycle redirect
            flush_path = rows[r].target;
            @(negedge clk);
            flush      = 1'b0;
         end
         err_start = chk.errors;
         got_start = chk.checked;
         toggle_en = rows[r].toggle;
         wait_insts(r, int'(rows[r].count));
         toggle_en = 1'b0;
         if (!timed_out) begin
            $display("Row %0d target %h: %0d instructions, %0d errors",
                     r, rows[r].target, chk.checked - got_start, chk.errors - err_start);
            rows_done++;
         end
      end
      $display("Rows %0d, instructions %0d, errors %0d", rows_done, chk.checked, chk.errors);
      if (!timed_out && chk.errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb.f ====
ifu_cfg_pkg.sv
ifu_pkt_pkg.sv
ifu_fifo.sv
ifu_fetch_ctl.sv
ifu_aligner.sv
ifu_top.sv
ifu_props.sv
ifu_checker.sv
tb_ifu.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_ifu
FILELIST  := tb.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Some tests failed
PASS_MSG  := All tests passed
SRCS      := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
